/* verilog/rice_bus_pkg.sv */
package rice_bus_pkg;

  // Default bus widths.
  localparam int RICE_ADDRESS_WIDTH = 32;
  localparam int RICE_DATA_WIDTH    = 32;

  // Access kind, taken from the byte strobe.
  typedef enum logic {
    RICE_READ  = 1'b0,  // Strobe all zero.
    RICE_WRITE = 1'b1   // Any strobe bit set.
  } rice_bus_access_e;

endpackage

/* verilog/rice_bus_skid_slice.sv */
`timescale 1ns/1ps

module rice_bus_skid_slice #(
  parameter int WIDTH = 32
)(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_valid,
  output logic              o_ready,
  input  logic [WIDTH-1:0]  i_data,
  output logic              o_valid,
  input  logic              i_ready,
  output logic [WIDTH-1:0]  o_data
);
  logic             main_valid;
  logic [WIDTH-1:0] main_data;
  logic [WIDTH-1:0] skid_data;
  logic             ready_q;    // Low while the skid entry holds an item.
  logic             main_free;
  logic             accept;

  // Main register is empty or hands its item on this cycle.
  assign main_free = !main_valid || i_ready;
  assign accept    = i_valid && ready_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      main_valid <= 1'b0;
      ready_q    <= 1'b1;
    end else if (main_free) begin
      if (!ready_q) begin
        main_valid <= 1'b1;   // Skid item moves up.
        ready_q    <= 1'b1;
      end else begin
        main_valid <= accept;
      end
    end else if (accept) begin
      ready_q <= 1'b0;        // Stalled output, item parks in skid.
    end
  end

  always_ff @(posedge i_clk) begin
    if (main_free) begin
      main_data <= (ready_q) ? i_data : skid_data;
    end
    if (accept && !main_free) begin
      skid_data <= i_data;
    end
  end

  assign o_valid = main_valid;
  assign o_data  = main_data;
  assign o_ready = ready_q;

endmodule

/* verilog/rice_bus_slicer.sv */
`timescale 1ns/1ps

module rice_bus_slicer #(
  parameter int ADDRESS_WIDTH   = rice_bus_pkg::RICE_ADDRESS_WIDTH,
  parameter int DATA_WIDTH      = rice_bus_pkg::RICE_DATA_WIDTH,
  parameter int REQUEST_STAGES  = 1,
  parameter int RESPONSE_STAGES = 1
)(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_request_valid,
  output logic                      o_request_ready,
  input  logic [ADDRESS_WIDTH-1:0]  i_address,
  input  logic [DATA_WIDTH/8-1:0]   i_strobe,
  input  logic [DATA_WIDTH-1:0]     i_write_data,
  output logic                      o_response_valid,
  input  logic                      i_response_ready,
  output logic [DATA_WIDTH-1:0]     o_read_data,
  output logic                      o_error,
  output logic                      o_m_request_valid,
  input  logic                      i_m_request_ready,
  output logic [ADDRESS_WIDTH-1:0]  o_m_address,
  output logic [DATA_WIDTH/8-1:0]   o_m_strobe,
  output logic [DATA_WIDTH-1:0]     o_m_write_data,
  input  logic                      i_m_response_valid,
  output logic                      o_m_response_ready,
  input  logic [DATA_WIDTH-1:0]     i_m_read_data,
  input  logic                      i_m_error
);
  localparam int STROBE_WIDTH   = DATA_WIDTH / 8;
  localparam int REQUEST_WIDTH  = ADDRESS_WIDTH + STROBE_WIDTH + DATA_WIDTH;
  localparam int RESPONSE_WIDTH = DATA_WIDTH + 1;

  // Node k sits in front of stage k; the last node faces the far side.
  logic [REQUEST_STAGES:0]      request_valid;
  logic [REQUEST_STAGES:0]      request_ready;
  logic [REQUEST_WIDTH-1:0]     request_data [REQUEST_STAGES+1];
  logic [RESPONSE_STAGES:0]     response_valid;
  logic [RESPONSE_STAGES:0]     response_ready;
  logic [RESPONSE_WIDTH-1:0]    response_data [RESPONSE_STAGES+1];

  assign request_valid[0]  = i_request_valid;
  assign request_data[0]   = {i_address, i_strobe, i_write_data};
  assign o_request_ready   = request_ready[0];

  assign o_m_request_valid = request_valid[REQUEST_STAGES];
  assign {o_m_address, o_m_strobe, o_m_write_data} = request_data[REQUEST_STAGES];
  assign request_ready[REQUEST_STAGES] = i_m_request_ready;

  assign response_valid[0]  = i_m_response_valid;
  assign response_data[0]   = {i_m_read_data, i_m_error};
  assign o_m_response_ready = response_ready[0];

  assign o_response_valid = response_valid[RESPONSE_STAGES];
  assign {o_read_data, o_error} = response_data[RESPONSE_STAGES];
  assign response_ready[RESPONSE_STAGES] = i_response_ready;

  // With zero stages both ends share node 0, a plain wire path.
  for (genvar i = 0; i < REQUEST_STAGES; i++) begin : g_request
    rice_bus_skid_slice #(
      .WIDTH  (REQUEST_WIDTH  )
    ) u_slice (
      .i_clk    (i_clk              ),
      .i_rst_n  (i_rst_n            ),
      .i_valid  (request_valid[i]   ),
      .o_ready  (request_ready[i]   ),
      .i_data   (request_data[i]    ),
      .o_valid  (request_valid[i+1] ),
      .i_ready  (request_ready[i+1] ),
      .o_data   (request_data[i+1]  )
    );
  end

  for (genvar i = 0; i < RESPONSE_STAGES; i++) begin : g_response
    rice_bus_skid_slice #(
      .WIDTH  (RESPONSE_WIDTH )
    ) u_slice (
      .i_clk    (i_clk                ),
      .i_rst_n  (i_rst_n              ),
      .i_valid  (response_valid[i]    ),
      .o_ready  (response_ready[i]    ),
      .i_data   (response_data[i]     ),
      .o_valid  (response_valid[i+1]  ),
      .i_ready  (response_ready[i+1]  ),
      .o_data   (response_data[i+1]   )
    );
  end

endmodule

/* verilog/rice_bus_sram_slave.sv */
`timescale 1ns/1ps

module rice_bus_sram_slave #(
  parameter int ADDRESS_WIDTH = rice_bus_pkg::RICE_ADDRESS_WIDTH,
  parameter int DATA_WIDTH    = rice_bus_pkg::RICE_DATA_WIDTH,
  parameter int MEMORY_WORDS  = 256
)(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_request_valid,
  output logic                      o_request_ready,
  input  logic [ADDRESS_WIDTH-1:0]  i_address,
  input  logic [DATA_WIDTH/8-1:0]   i_strobe,
  input  logic [DATA_WIDTH-1:0]     i_write_data,
  output logic                      o_response_valid,
  input  logic                      i_response_ready,
  output logic [DATA_WIDTH-1:0]     o_read_data,
  output logic                      o_error
);
  import rice_bus_pkg::*;

  localparam int STROBE_WIDTH    = DATA_WIDTH / 8;
  localparam int OFFSET_BITS     = (STROBE_WIDTH > 1) ? $clog2(STROBE_WIDTH) : 0;
  localparam int INDEX_WIDTH     = ADDRESS_WIDTH - OFFSET_BITS;
  localparam int MEM_INDEX_WIDTH = (MEMORY_WORDS > 1) ? $clog2(MEMORY_WORDS) : 1;

  logic [DATA_WIDTH-1:0]      mem [MEMORY_WORDS];
  rice_bus_access_e           access;
  logic [INDEX_WIDTH-1:0]     word_index;
  logic [MEM_INDEX_WIDTH-1:0] mem_index;
  logic                       in_range;
  logic                       take;
  logic                       response_valid;
  logic [DATA_WIDTH-1:0]      read_data;
  logic                       error;

  assign access     = (|i_strobe) ? RICE_WRITE : RICE_READ;
  assign word_index = i_address[ADDRESS_WIDTH-1:OFFSET_BITS]; // Drop byte offset.
  assign mem_index  = word_index[MEM_INDEX_WIDTH-1:0];
  assign in_range   = word_index < MEMORY_WORDS;

  // Free slot, or the held response leaves this cycle.
  assign o_request_ready = !response_valid || i_response_ready;
  assign take            = i_request_valid && o_request_ready;

  always_ff @(posedge i_clk) begin
    if (take && in_range && (access == RICE_WRITE)) begin
      for (int b = 0; b < STROBE_WIDTH; b++) begin
        if (i_strobe[b]) begin
          mem[mem_index][8*b+:8] <= i_write_data[8*b+:8];
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      response_valid <= 1'b0;
    end else if (take) begin
      response_valid <= 1'b1;
    end else if (i_response_ready) begin
      response_valid <= 1'b0;
    end
  end

  // Payload held while the response is stalled.
  always_ff @(posedge i_clk) begin
    if (take) begin
      if (in_range && (access == RICE_READ)) begin
        read_data <= mem[mem_index];
      end else begin
        read_data <= '0;      // Writes and errors return zero.
      end
      error <= !in_range;
    end
  end

  assign o_response_valid = response_valid;
  assign o_read_data      = read_data;
  assign o_error          = error;

endmodule

/* verilog/rice_bus_subsystem_top.sv */
`timescale 1ns/1ps

module rice_bus_subsystem_top #(
  parameter int ADDRESS_WIDTH   = rice_bus_pkg::RICE_ADDRESS_WIDTH,
  parameter int DATA_WIDTH      = rice_bus_pkg::RICE_DATA_WIDTH,
  parameter int REQUEST_STAGES  = 1,
  parameter int RESPONSE_STAGES = 1,
  parameter int MEMORY_WORDS    = 256
)(
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_request_valid,
  output logic                      o_request_ready,
  input  logic [ADDRESS_WIDTH-1:0]  i_address,
  input  logic [DATA_WIDTH/8-1:0]   i_strobe,
  input  logic [DATA_WIDTH-1:0]     i_write_data,
  output logic                      o_response_valid,
  input  logic                      i_response_ready,
  output logic [DATA_WIDTH-1:0]     o_read_data,
  output logic                      o_error
);
  // Slicer to memory links.
  logic                     m_request_valid;
  logic                     m_request_ready;
  logic [ADDRESS_WIDTH-1:0] m_address;
  logic [DATA_WIDTH/8-1:0]  m_strobe;
  logic [DATA_WIDTH-1:0]    m_write_data;
  logic                     m_response_valid;
  logic                     m_response_ready;
  logic [DATA_WIDTH-1:0]    m_read_data;
  logic                     m_error;

  rice_bus_slicer #(
    .ADDRESS_WIDTH    (ADDRESS_WIDTH    ),
    .DATA_WIDTH       (DATA_WIDTH       ),
    .REQUEST_STAGES   (REQUEST_STAGES   ),
    .RESPONSE_STAGES  (RESPONSE_STAGES  )
  ) u_slicer (
    .i_clk              (i_clk            ),
    .i_rst_n            (i_rst_n          ),
    .i_request_valid    (i_request_valid  ),
    .o_request_ready    (o_request_ready  ),
    .i_address          (i_address        ),
    .i_strobe           (i_strobe         ),
    .i_write_data       (i_write_data     ),
    .o_response_valid   (o_response_valid ),
    .i_response_ready   (i_response_ready ),
    .o_read_data        (o_read_data      ),
    .o_error            (o_error          ),
    .o_m_request_valid  (m_request_valid  ),
    .i_m_request_ready  (m_request_ready  ),
    .o_m_address        (m_address        ),
    .o_m_strobe         (m_strobe         ),
    .o_m_write_data     (m_write_data     ),
    .i_m_response_valid (m_response_valid ),
    .o_m_response_ready (m_response_ready ),
    .i_m_read_data      (m_read_data      ),
    .i_m_error          (m_error          )
  );

  rice_bus_sram_slave #(
    .ADDRESS_WIDTH  (ADDRESS_WIDTH  ),
    .DATA_WIDTH     (DATA_WIDTH     ),
    .MEMORY_WORDS   (MEMORY_WORDS   )
  ) u_sram (
    .i_clk            (i_clk            ),
    .i_rst_n          (i_rst_n          ),
    .i_request_valid  (m_request_valid  ),
    .o_request_ready  (m_request_ready  ),
    .i_address        (m_address        ),
    .i_strobe         (m_strobe         ),
    .i_write_data     (m_write_data     ),
    .o_response_valid (m_response_valid ),
    .i_response_ready (m_response_ready ),
    .o_read_data      (m_read_data      ),
    .o_error          (m_error          )
  );

endmodule

/* dv/rice_bus_chk.sv */
`timescale 1ns/1ps

module rice_bus_chk #(
  parameter int ADDRESS_WIDTH = rice_bus_pkg::RICE_ADDRESS_WIDTH,
  parameter int DATA_WIDTH    = rice_bus_pkg::RICE_DATA_WIDTH
)(
  input logic                     i_clk,
  input logic                     i_rst_n,
  input logic                     i_request_valid,
  input logic                     i_request_ready,
  input logic [ADDRESS_WIDTH-1:0] i_address,
  input logic [DATA_WIDTH/8-1:0]  i_strobe,
  input logic [DATA_WIDTH-1:0]    i_write_data,
  input logic                     i_response_valid,
  input logic                     i_response_ready,
  input logic [DATA_WIDTH-1:0]    i_read_data,
  input logic                     i_error
);
  int outstanding;  // Requests taken minus responses taken.
  int failures = 0;

  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(i_request_valid && i_request_ready)
                     - int'(i_response_valid && i_response_ready);
    end
  end

  a_request_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_request_valid && !i_request_ready |=>
      i_request_valid && $stable({i_address, i_strobe, i_write_data}))
    else begin
      failures++;
      $error("request changed while stalled");
    end

  a_response_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_response_valid && !i_response_ready |=> i_response_valid && $stable({i_read_data, i_error}))
    else begin
      failures++;
      $error("response changed while stalled");
    end

  a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> !i_response_valid)
    else begin
      failures++;
      $error("response valid during reset");
    end

  a_response_owed: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_response_valid |-> outstanding > 0)
    else begin
      failures++;
      $error("response without an outstanding request");
    end

endmodule

bind rice_bus_subsystem_top rice_bus_chk #(
  .ADDRESS_WIDTH  (ADDRESS_WIDTH  ),
  .DATA_WIDTH     (DATA_WIDTH     )
) u_chk (
  .i_clk            (i_clk            ),
  .i_rst_n          (i_rst_n          ),
  .i_request_valid  (i_request_valid  ),
  .i_request_ready  (o_request_ready  ),
  .i_address        (i_address        ),
  .i_strobe         (i_strobe         ),
  .i_write_data     (i_write_data     ),
  .i_response_valid (o_response_valid ),
  .i_response_ready (i_response_ready ),
  .i_read_data      (o_read_data      ),
  .i_error          (o_error          )
);

/* dv/rice_bus_scoreboard.sv */
`timescale 1ns/1ps

module rice_bus_scoreboard #(
  parameter int ADDRESS_WIDTH = rice_bus_pkg::RICE_ADDRESS_WIDTH,
  parameter int DATA_WIDTH    = rice_bus_pkg::RICE_DATA_WIDTH,
  parameter int MEMORY_WORDS  = 256
)(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_request_valid,
  input  logic                     i_request_ready,
  input  logic [ADDRESS_WIDTH-1:0] i_address,
  input  logic [DATA_WIDTH/8-1:0]  i_strobe,
  input  logic [DATA_WIDTH-1:0]    i_write_data,
  input  logic                     i_response_valid,
  input  logic                     i_response_ready,
  input  logic [DATA_WIDTH-1:0]    i_read_data,
  input  logic                     i_error,
  input  logic                     i_burst,
  input  logic                     i_done,
  output int                       o_outstanding,
  output int                       o_compare_errors,
  output int                       o_throughput_errors
);
  import rice_bus_pkg::*;

  localparam int STROBE_WIDTH = DATA_WIDTH / 8;

  logic [DATA_WIDTH-1:0]    model [MEMORY_WORDS];
  logic [DATA_WIDTH:0]      expected_q [$];  // {read data, error}.
  logic [DATA_WIDTH:0]      expected;
  logic [ADDRESS_WIDTH-1:0] word;
  rice_bus_access_e         kind;
  int                       burst_cycles = 0;
  int                       burst_transfers = 0;

  initial begin
    o_outstanding       = 0;
    o_compare_errors    = 0;
    o_throughput_errors = 0;
  end

  always @(posedge i_clk) begin
    if (i_rst_n) begin
      // Pop first, a response never belongs to a request of the same edge.
      if (i_response_valid && i_response_ready) begin
        if (expected_q.size() == 0) begin
          $display("ERROR %0t: response with no outstanding request", $time);
          o_compare_errors++;
        end else begin
          expected = expected_q.pop_front();
          if ({i_read_data, i_error} !== expected) begin
            $display("ERROR %0t: got data %h error %b, expected data %h error %b", $time,
                     i_read_data, i_error, expected[DATA_WIDTH:1], expected[0]);
            o_compare_errors++;
          end
        end
      end
      if (i_request_valid && i_request_ready) begin
        kind = (i_strobe != '0) ? RICE_WRITE : RICE_READ;
        word = i_address / STROBE_WIDTH;
        if (word >= MEMORY_WORDS) begin
          expected = {{DATA_WIDTH{1'b0}}, 1'b1};  // Out of range, memory untouched.
        end else if (kind == RICE_WRITE) begin
          for (int b = 0; b < STROBE_WIDTH; b++) begin
            if (i_strobe[b]) model[word][8*b+:8] = i_write_data[8*b+:8];
          end
          expected = '0;
        end else begin
          expected = {model[word], 1'b0};
        end
        expected_q.push_back(expected);
      end
      if (i_burst) begin
        burst_cycles++;
        if (i_request_valid && i_request_ready) burst_transfers++;
      end
      o_outstanding = expected_q.size();
    end
  end

  // Back-to-back stretch must move one request every cycle.
  always @(negedge i_burst) begin
    if (burst_transfers != burst_cycles) begin
      $display("ERROR %0t: %0d request transfers in %0d stretch cycles", $time,
               burst_transfers, burst_cycles);
      o_throughput_errors++;
    end
  end

  always @(posedge i_done) begin
    if (expected_q.size() != 0) begin
      $display("%0d requests never received a response", expected_q.size());
    end
  end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
  localparam int ADDRESS_WIDTH   = rice_bus_pkg::RICE_ADDRESS_WIDTH;
  localparam int DATA_WIDTH      = rice_bus_pkg::RICE_DATA_WIDTH;
  localparam int STROBE_WIDTH    = DATA_WIDTH / 8;
  localparam int REQUEST_STAGES  = 1;
  localparam int RESPONSE_STAGES = 1;
  localparam int MEMORY_WORDS    = 256;
  localparam int NUM_REQUESTS    = 2000;
  localparam int BURST_REQUESTS  = 64;
  localparam int MAX_GAP         = 3;
  localparam int TIMEOUT_CYCLES  = NUM_REQUESTS * (MAX_GAP + 1) * 20;

  logic                     i_clk = 1'b0;
  logic                     i_rst_n;
  logic                     i_request_valid;
  logic                     o_request_ready;
  logic [ADDRESS_WIDTH-1:0] i_address;
  logic [STROBE_WIDTH-1:0]  i_strobe;
  logic [DATA_WIDTH-1:0]    i_write_data;
  logic                     o_response_valid;
  logic                     i_response_ready;
  logic [DATA_WIDTH-1:0]    o_read_data;
  logic                     o_error;
  logic                     burst;
  logic                     done;
  integer                   seed = 32'h70ba868a;
  int                       outstanding;
  int                       compare_errors;
  int                       throughput_errors;
  int                       total;

  always #2 i_clk = ~i_clk;

  rice_bus_subsystem_top #(
    .ADDRESS_WIDTH    (ADDRESS_WIDTH    ),
    .DATA_WIDTH       (DATA_WIDTH       ),
    .REQUEST_STAGES   (REQUEST_STAGES   ),
    .RESPONSE_STAGES  (RESPONSE_STAGES  ),
    .MEMORY_WORDS     (MEMORY_WORDS     )
  ) i_dut (.*);

  rice_bus_scoreboard #(
    .ADDRESS_WIDTH  (ADDRESS_WIDTH  ),
    .DATA_WIDTH     (DATA_WIDTH     ),
    .MEMORY_WORDS   (MEMORY_WORDS   )
  ) u_scoreboard (
    .i_request_ready      (o_request_ready    ),
    .i_response_valid     (o_response_valid   ),
    .i_read_data          (o_read_data        ),
    .i_error              (o_error            ),
    .i_burst              (burst              ),
    .i_done               (done               ),
    .o_outstanding        (outstanding        ),
    .o_compare_errors     (compare_errors     ),
    .o_throughput_errors  (throughput_errors  ),
    .*
  );

  task automatic update_response_ready();
    if (burst) i_response_ready = 1'b1;
    else i_response_ready = ({$random(seed)} % 3) != 0;  // Low about a third of the time.
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(negedge i_clk);
      update_response_ready();
    end
  endtask

  task automatic send_request(input logic [ADDRESS_WIDTH-1:0] address,
                              input logic [STROBE_WIDTH-1:0] strobe,
                              input logic [DATA_WIDTH-1:0] data);
    logic accepted;
    i_request_valid = 1'b1;
    i_address       = address;
    i_strobe        = strobe;
    i_write_data    = data;
    accepted        = 1'b0;
    while (!accepted) begin
      @(posedge i_clk);
      accepted = o_request_ready;
      @(negedge i_clk);
      update_response_ready();
    end
    i_request_valid = 1'b0;
  endtask

  task automatic send_random_request();
    logic [ADDRESS_WIDTH-1:0] word;
    logic [STROBE_WIDTH-1:0]  strobe;
    if ({$random(seed)} % 8 == 0) word = MEMORY_WORDS + {$random(seed)} % 1024;
    else word = {$random(seed)} % MEMORY_WORDS;
    strobe = (($random(seed) & 1) != 0) ? STROBE_WIDTH'($random(seed)) : '0;
    send_request(word * STROBE_WIDTH + {$random(seed)} % STROBE_WIDTH, strobe, $random(seed));
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    while (outstanding != 0 && cycles < 200) begin
      idle_cycles(1);
      cycles++;
    end
  endtask

  initial begin
    i_rst_n          = 1'b0;
    i_request_valid  = 1'b0;
    i_address        = '0;
    i_strobe         = '0;
    i_write_data     = '0;
    i_response_ready = 1'b0;
    burst            = 1'b0;
    done             = 1'b0;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    for (int i = 0; i < MEMORY_WORDS; i++) begin  // Defines every word.
      send_request(i * STROBE_WIDTH, '1, $random(seed));
      idle_cycles({$random(seed)} % (MAX_GAP + 1));
    end
    for (int i = MEMORY_WORDS; i < NUM_REQUESTS - BURST_REQUESTS; i++) begin
      send_random_request();
      idle_cycles({$random(seed)} % (MAX_GAP + 1));
    end
    wait_for_drain();
    burst = 1'b1;
    i_response_ready = 1'b1;
    for (int i = 0; i < BURST_REQUESTS; i++) begin
      send_request((i * 37 % MEMORY_WORDS) * STROBE_WIDTH, '0, '0);
    end
    burst = 1'b0;
    wait_for_drain();
    done = 1'b1;
    @(negedge i_clk);
    total = compare_errors + throughput_errors + outstanding + i_dut.u_chk.failures;
    $display("Errors: compare %0d, throughput %0d, unanswered %0d, assertion %0d",
             compare_errors, throughput_errors, outstanding, i_dut.u_chk.failures);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge i_clk);
    $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* verilog.f */
verilog/rice_bus_pkg.sv
verilog/rice_bus_skid_slice.sv
verilog/rice_bus_slicer.sv
verilog/rice_bus_sram_slave.sv
verilog/rice_bus_subsystem_top.sv
dv/rice_bus_chk.sv
dv/rice_bus_scoreboard.sv
dv/tb_top.sv

/* Makefile */
TOP = tb_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
